/* list.f */
+incdir+tests
hw/host_pkg.sv
hw/credit_if.sv
hw/credit_fifo.sv
hw/cmd_parser.sv
hw/resp_framer.sv
hw/ft_host_bridge.sv
tests/bridge_props.sv
tests/tb_ft_host_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# build and run tb_ft_host_bridge with Verilator, then scan the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module tb_ft_host_bridge -f list.f -o sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

/* tests/host_model.svh */
// reference model of the bridge rules; include inside the testbench module after importing host_pkg
`ifndef HOST_MODEL_SVH
`define HOST_MODEL_SVH

typedef struct packed {
	host_req_t req;
	logic last;
} exp_item_t;

// one master handshake on the response side
typedef struct packed {
	byte_t status;
	logic [31:0] addr;
	logic [31:0] data;
	logic [COUNT_W-1:0] count;
} rsp_beat_t;

// bit 8 of rx and tx entries is the last flag
logic [8:0] rx_q [$];
logic [8:0] exp_tx_q [$];
exp_item_t exp_req_q [$];
rsp_beat_t rsp_q [$];
byte_t frame_q [$];

function automatic logic [31:0] id_dword(byte_t id);
	return {24'($urandom), id};
endfunction

// most significant byte first
function automatic void put_dword(logic [31:0] dw);
	for (int b = 3; b >= 0; b--) begin
		frame_q.push_back(dw[8*b +: 8]);
	end
endfunction

// first len bytes of the built frame, rx_last on the final one
function automatic void send_frame(int len);
	for (int i = 0; i < len; i++) begin
		rx_q.push_back({i == len - 1, frame_q[i]});
	end
	frame_q.delete();
endfunction

function automatic void expect_item(opcode_e op, logic [31:0] addr, logic [31:0] data,
		logic last);
	exp_item_t e;
	e.req.opcode = op;
	e.req.addr = addr;
	e.req.data = data;
	e.last = last;
	exp_req_q.push_back(e);
endfunction

function automatic void add_ping();
	put_dword(id_dword(HOST_ID_IN));
	put_dword({4'($urandom), OP_PING, 24'($urandom)});
	expect_item(OP_PING, 32'h0, 32'h0, 1'b1);
	send_frame(8);
endfunction

function automatic void add_read();
	logic [31:0] addr;
	addr = $urandom;
	put_dword(id_dword(HOST_ID_IN));
	put_dword({4'($urandom), OP_READ, 24'($urandom)});
	put_dword(addr);
	expect_item(OP_READ, addr, 32'h0, 1'b1);
	send_frame(12);
endfunction

// cut above zero ends the frame early after that many bytes
function automatic void add_write(int count, int cut);
	logic [31:0] addr;
	logic [31:0] data;
	int n;
	int len;
	n = (count == 0) ? 1 : count;
	len = (cut > 0) ? cut : 12 + 4 * n;
	addr = $urandom;
	put_dword(id_dword(HOST_ID_IN));
	put_dword({4'($urandom), OP_WRITE, 24'(count)});
	put_dword(addr);
	for (int i = 0; i < n; i++) begin
		data = $urandom;
		put_dword(data);
		// only words that arrived complete become items
		if (16 + 4 * i <= len) begin
			expect_item(OP_WRITE, addr, data, i == n - 1);
		end
	end
	send_frame(len);
endfunction

function automatic void add_cut_write();
	int count;
	count = $urandom_range(1, 4);
	add_write(count, $urandom_range(9, 11 + 4 * count));
endfunction

function automatic void add_bad_id();
	byte_t id;
	int extra;
	id = 8'($urandom);
	if (id == HOST_ID_IN) begin
		id = 8'h00;
	end
	extra = $urandom_range(1, 3);
	put_dword(id_dword(id));
	for (int i = 0; i < extra; i++) begin
		put_dword($urandom);
	end
	send_frame(frame_q.size());
endfunction

function automatic void add_bad_opcode();
	int extra;
	extra = $urandom_range(0, 2);
	put_dword(id_dword(HOST_ID_IN));
	put_dword({4'($urandom), 4'($urandom_range(3, 15)), 24'($urandom)});
	for (int i = 0; i < extra; i++) begin
		put_dword($urandom);
	end
	send_frame(frame_q.size());
endfunction

function automatic void expect_dword(logic [31:0] dw, logic last);
	for (int b = 3; b >= 0; b--) begin
		exp_tx_q.push_back({last && (b == 0), dw[8*b +: 8]});
	end
endfunction

// kind 0 error, 1 ack, 2 data
function automatic void add_response(int kind);
	rsp_beat_t beat;
	logic [3:0] nib;
	int words;
	case (kind)
		0: nib = STATUS_ERR;
		1: nib = 4'($urandom_range(0, 12));
		default: nib = STATUS_DATA;
	endcase
	beat.status = {4'($urandom), nib};
	beat.addr = $urandom;
	beat.data = $urandom;
	beat.count = (kind == 2) ? 24'($urandom_range(0, 3)) : 24'($urandom);
	words = (kind == 2) ? int'(beat.count) + 1 : 0;
	rsp_q.push_back(beat);
	exp_tx_q.push_back({1'b0, HOST_ID_OUT});
	expect_dword({beat.status, (kind == 2) ? beat.count + 24'd1 : 24'd0}, kind == 0);
	if (kind != 0) begin
		expect_dword(beat.addr, kind == 1);
	end
	for (int w = 0; w < words; w++) begin
		// every further word comes with its own handshake
		if (w > 0) begin
			beat.data = $urandom;
			rsp_q.push_back(beat);
		end
		expect_dword(beat.data, w == words - 1);
	end
endfunction

`endif

/* tests/tb_ft_host_bridge.sv */
// fixed seed 83959; checks every req and tx handshake against the model queues in host_model.svh
module tb_ft_host_bridge;

	import host_pkg::*;

	localparam int REQ_DEPTH = 4;
	localparam int TX_DEPTH = 8;
	localparam int SEED = 83959;

	logic clk;
	logic rst;
	logic rx_valid;
	byte_t rx_data;
	logic rx_last;
	logic rx_ready;
	logic req_valid;
	opcode_e req_opcode;
	logic [31:0] req_addr;
	logic [31:0] req_data;
	logic req_last;
	logic req_ready;
	logic rsp_valid;
	byte_t rsp_status;
	logic [31:0] rsp_addr;
	logic [31:0] rsp_data;
	logic [COUNT_W-1:0] rsp_count;
	logic rsp_ready;
	logic tx_valid;
	byte_t tx_data;
	logic tx_last;
	logic tx_ready;

	int errors;
	int checks;
	int last_errors;
	int last_checks;
	int cycles;
	int limit;
	bit stall;
	string cur_test;

	`include "host_model.svh"

	ft_host_bridge #(.REQ_DEPTH(REQ_DEPTH), .TX_DEPTH(TX_DEPTH)) uut (.*);

	always #4 clk = ~clk;

	function automatic void check_value(string sig, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error: %s got 0x%h expected 0x%h in test %s", sig, got, exp, cur_test);
			errors++;
		end
	endfunction

	function automatic void check_request();
		exp_item_t e;
		checks++;
		assert (exp_req_q.size() != 0) else begin
			$display("unexpected request item in test %s, no frame should produce it", cur_test);
			errors++;
		end
		if (exp_req_q.size() != 0) begin
			e = exp_req_q.pop_front();
			check_value("req_opcode", 32'(req_opcode), 32'(e.req.opcode));
			check_value("req_addr", req_addr, e.req.addr);
			check_value("req_data", req_data, e.req.data);
			check_value("req_last", 32'(req_last), 32'(e.last));
		end
	endfunction

	function automatic void check_tx_byte();
		logic [8:0] e;
		checks++;
		assert (exp_tx_q.size() != 0) else begin
			$display("unexpected tx byte in test %s, no response frame left", cur_test);
			errors++;
		end
		if (exp_tx_q.size() != 0) begin
			e = exp_tx_q.pop_front();
			check_value("tx_data", 32'(tx_data), 32'(e[7:0]));
			check_value("tx_last", 32'(tx_last), 32'(e[8]));
		end
	endfunction

	// rx byte stream with random gaps while stalling
	always @(posedge clk) begin
		if (rst) begin
			rx_valid <= 1'b0;
		end else begin
			if (rx_valid && rx_ready) begin
				void'(rx_q.pop_front());
			end
			if (rx_q.size() != 0 && !(stall && $urandom % 4 == 0)) begin
				rx_valid <= 1'b1;
				rx_data <= rx_q[0][7:0];
				rx_last <= rx_q[0][8];
			end else begin
				rx_valid <= 1'b0;
				rx_last <= 1'b0;
			end
		end
	end

	// master response beats
	always @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			if (rsp_valid && rsp_ready) begin
				void'(rsp_q.pop_front());
			end
			if (rsp_q.size() != 0 && !(stall && $urandom % 4 == 0)) begin
				rsp_valid <= 1'b1;
				rsp_status <= rsp_q[0].status;
				rsp_addr <= rsp_q[0].addr;
				rsp_data <= rsp_q[0].data;
				rsp_count <= rsp_q[0].count;
			end else begin
				rsp_valid <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		req_ready <= !stall || ($urandom % 4 != 0);
		tx_ready <= !stall || ($urandom % 3 != 0);
	end

	always @(posedge clk) begin
		if (!rst && req_valid && req_ready) begin
			check_request();
		end
		if (!rst && tx_valid && tx_ready) begin
			check_tx_byte();
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout in test %s: nothing finished within %0d cycles", cur_test, limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic run_test(string name);
		cur_test = name;
		cycles = 0;
		limit = 4 * (rx_q.size() + rsp_q.size() + exp_req_q.size() + exp_tx_q.size()) + 200;
		while (rx_q.size() + rsp_q.size() + exp_req_q.size() + exp_tx_q.size() != 0) begin
			@(negedge clk);
		end
		$display("test %-10s done: %0d checks, %0d errors", name, checks - last_checks,
			errors - last_errors);
		last_checks = checks;
		last_errors = errors;
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst = 1'b1;
		rx_valid = 1'b0;
		rx_data = '0;
		rx_last = 1'b0;
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp_status = '0;
		rsp_addr = '0;
		rsp_data = '0;
		rsp_count = '0;
		tx_ready = 1'b0;
		stall = 1'b0;
		errors = 0;
		checks = 0;
		last_errors = 0;
		last_checks = 0;
		cycles = 0;
		limit = 200;
		cur_test = "reset";
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// first cycle out of reset
		@(negedge clk);
		check_value("rx_ready", 32'(rx_ready), 32'h0);
		check_value("req_valid", 32'(req_valid), 32'h0);
		check_value("tx_valid", 32'(tx_valid), 32'h0);
		check_value("tx_last", 32'(tx_last), 32'h0);
		check_value("rsp_ready", 32'(rsp_ready), 32'h0);
		// rsp_ready comes up one cycle later
		@(negedge clk);
		check_value("rsp_ready", 32'(rsp_ready), 32'h1);
		run_test("reset");
		for (int i = 0; i < 4; i++) begin
			add_ping();
		end
		run_test("ping");
		for (int i = 0; i < 6; i++) begin
			add_write($urandom_range(0, 5), 0);
		end
		run_test("write");
		for (int i = 0; i < 4; i++) begin
			add_read();
		end
		run_test("read");
		// each bad frame followed by a good one
		for (int i = 0; i < 3; i++) begin
			add_bad_id();
			add_ping();
			add_bad_opcode();
			add_read();
			add_cut_write();
			add_write($urandom_range(1, 3), 0);
		end
		run_test("bad_frame");
		for (int i = 0; i < 6; i++) begin
			add_response(i % 3);
		end
		run_test("response");
		stall = 1'b1;
		for (int i = 0; i < 24; i++) begin
			case ($urandom_range(0, 5))
				0: add_ping();
				1: add_write($urandom_range(0, 5), 0);
				2: add_read();
				3: add_bad_id();
				4: add_bad_opcode();
				default: add_cut_write();
			endcase
		end
		for (int i = 0; i < 10; i++) begin
			add_response($urandom_range(0, 2));
		end
		run_test("stall_mix");
		stall = 1'b0;
		cycles = 0;
		// quiet period so stray items or bytes still get flagged
		repeat (20) @(posedge clk);
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tests/bridge_props.sv */
// bound to every credit_fifo; uses its internal count and push signals
module bridge_props #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic [$clog2(DEPTH + 1)-1:0] count,
	input logic push,
	input logic out_valid,
	input payload_t out_payload,
	input logic out_last,
	input logic out_ready
);

	fill_limit: assert property (@(posedge clk) disable iff (rst) int'(count) <= DEPTH)
		else $error("credit queue fill count %0d above depth %0d", count, DEPTH);

	// the sender's credits must stop it before the queue overflows
	no_push_full: assert property (@(posedge clk) disable iff (rst)
		!(push && int'(count) == DEPTH))
		else $error("enqueue into a full credit queue of depth %0d", DEPTH);

	// a stalled head entry stays put until it is popped
	hold_valid: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_payload) && $stable(out_last))
		else $error("credit queue changed or dropped its head entry before it was popped");

endmodule

bind credit_fifo bridge_props #(.payload_t(payload_t), .DEPTH(DEPTH)) props (
	.clk(clk),
	.rst(rst),
	.count(count),
	.push(push),
	.out_valid(out_valid),
	.out_payload(out_payload),
	.out_last(out_last),
	.out_ready(out_ready)
);

/* hw/ft_host_bridge.sv */
// rx and tx byte streams stand in for the FT245 FIFOs; bad frames are dropped silently
module ft_host_bridge #(
	parameter int REQ_DEPTH = 4,
	parameter int TX_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic rx_valid,
	input host_pkg::byte_t rx_data,
	input logic rx_last,
	output logic rx_ready,
	output logic req_valid,
	output host_pkg::opcode_e req_opcode,
	output logic [31:0] req_addr,
	output logic [31:0] req_data,
	output logic req_last,
	input logic req_ready,
	input logic rsp_valid,
	input host_pkg::byte_t rsp_status,
	input logic [31:0] rsp_addr,
	input logic [31:0] rsp_data,
	input logic [host_pkg::COUNT_W-1:0] rsp_count,
	output logic rsp_ready,
	output logic tx_valid,
	output host_pkg::byte_t tx_data,
	output logic tx_last,
	input logic tx_ready
);

	import host_pkg::*;

	host_req_t req_item;

	credit_if #(.payload_t(host_req_t)) req_link ();
	credit_if #(.payload_t(byte_t)) tx_link ();

	// request path
	cmd_parser #(.DEPTH(REQ_DEPTH)) u_parser (
		.clk(clk),
		.rst(rst),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.rx_ready(rx_ready),
		.req(req_link.sender)
	);

	credit_fifo #(.payload_t(host_req_t), .DEPTH(REQ_DEPTH)) req_q (
		.clk(clk),
		.rst(rst),
		.enq(req_link.receiver),
		.out_valid(req_valid),
		.out_payload(req_item),
		.out_last(req_last),
		.out_ready(req_ready)
	);

	assign req_opcode = req_item.opcode;
	assign req_addr = req_item.addr;
	assign req_data = req_item.data;

	// response path
	resp_framer #(.DEPTH(TX_DEPTH)) u_framer (
		.clk(clk),
		.rst(rst),
		.rsp_valid(rsp_valid),
		.rsp_status(rsp_status),
		.rsp_addr(rsp_addr),
		.rsp_data(rsp_data),
		.rsp_count(rsp_count),
		.rsp_ready(rsp_ready),
		.tx(tx_link.sender)
	);

	credit_fifo #(.payload_t(byte_t), .DEPTH(TX_DEPTH)) tx_q (
		.clk(clk),
		.rst(rst),
		.enq(tx_link.receiver),
		.out_valid(tx_valid),
		.out_payload(tx_data),
		.out_last(tx_last),
		.out_ready(tx_ready)
	);

endmodule

/* hw/resp_framer.sv */
// only STATUS_ERR and STATUS_DATA change framing; further data words wait on new master handshakes
module resp_framer #(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic rsp_valid,
	input host_pkg::byte_t rsp_status,
	input logic [31:0] rsp_addr,
	input logic [31:0] rsp_data,
	input logic [host_pkg::COUNT_W-1:0] rsp_count,
	output logic rsp_ready,
	credit_if.sender tx
);

	import host_pkg::*;

	localparam int CW = $clog2(DEPTH + 1);

	typedef enum logic [2:0] {
		F_IDLE,
		F_ID,
		F_STAT,
		F_ADDR,
		F_DATA,
		F_WAIT
	} state_t;

	state_t state;
	logic [1:0] byte_cnt;
	logic [31:0] sh;
	byte_t status_q;
	logic [31:0] addr_q;
	logic [31:0] data_q;
	logic [COUNT_W-1:0] words_left;
	logic [COUNT_W-1:0] count_field;
	logic is_err;
	logic is_data;
	logic hs;
	logic dw_end;

	logic [CW-1:0] credit_cnt;
	logic fire;

	assign hs = rsp_valid && rsp_ready;
	assign is_err = (status_q[3:0] == STATUS_ERR);
	assign is_data = (status_q[3:0] == STATUS_DATA);
	// words_left still holds rsp_count while the status goes out
	assign count_field = is_data ? words_left + COUNT_W'(1) : '0;

	assign tx.valid = (state != F_IDLE) && (state != F_WAIT) && (credit_cnt != '0);
	assign tx.payload = (state == F_ID) ? HOST_ID_OUT : sh[31:24];
	assign fire = tx.valid;
	assign dw_end = (byte_cnt == 2'd3);

	assign tx.last = dw_end && (
		(state == F_STAT && is_err) ||
		(state == F_ADDR && !is_data) ||
		(state == F_DATA && words_left == '0));

	always_ff @(posedge clk) begin
		if (hs && state == F_IDLE) begin
			status_q <= rsp_status;
			addr_q <= rsp_addr;
			data_q <= rsp_data;
			words_left <= rsp_count;
		end
		// next data word goes straight into the shifter
		if (hs && state == F_WAIT) begin
			sh <= rsp_data;
		end
		if (fire) begin
			case (state)
				F_ID: sh <= {status_q, count_field};
				F_STAT: sh <= dw_end ? addr_q : {sh[23:0], 8'h0};
				F_ADDR: sh <= dw_end ? data_q : {sh[23:0], 8'h0};
				F_DATA: begin
					sh <= {sh[23:0], 8'h0};
					if (dw_end) begin
						words_left <= words_left - COUNT_W'(1);
					end
				end
				default: sh <= sh;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= F_IDLE;
			byte_cnt <= '0;
			rsp_ready <= 1'b0;
			credit_cnt <= CW'(DEPTH);
		end else begin
			case (state)
				F_IDLE: begin
					if (hs) begin
						rsp_ready <= 1'b0;
						state <= F_ID;
					end else begin
						rsp_ready <= 1'b1;
					end
				end
				F_ID: if (fire) state <= F_STAT;
				F_STAT: begin
					if (fire && dw_end) begin
						state <= is_err ? F_IDLE : F_ADDR;
					end
				end
				F_ADDR: begin
					if (fire && dw_end) begin
						state <= is_data ? F_DATA : F_IDLE;
					end
				end
				F_DATA: begin
					if (fire && dw_end) begin
						if (words_left == '0) begin
							state <= F_IDLE;
						end else begin
							state <= F_WAIT;
							rsp_ready <= 1'b1;
						end
					end
				end
				F_WAIT: begin
					if (hs) begin
						rsp_ready <= 1'b0;
						state <= F_DATA;
					end
				end
				default: state <= F_IDLE;
			endcase
			// byte counter wraps back to 0 at each dword end
			if (fire && state != F_ID) begin
				byte_cnt <= byte_cnt + 2'd1;
			end
			if (fire && !tx.credit) begin
				credit_cnt <= credit_cnt - CW'(1);
			end else if (!fire && tx.credit) begin
				credit_cnt <= credit_cnt + CW'(1);
			end
		end
	end

endmodule

/* hw/cmd_parser.sv */
// frames end on rx_last only; bad ID or opcode drops the rest of the frame, no error reply is sent
module cmd_parser #(
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic rx_valid,
	input host_pkg::byte_t rx_data,
	input logic rx_last,
	output logic rx_ready,
	credit_if.sender req
);

	import host_pkg::*;

	localparam int CW = $clog2(DEPTH + 1);

	typedef enum logic [2:0] {
		S_ID,
		S_CMD,
		S_ADDR,
		S_DATA,
		S_DISCARD
	} state_t;

	state_t state;
	state_t state_nx;
	logic run;
	logic [1:0] byte_cnt;
	logic [23:0] dword_q;
	logic [31:0] full_dw;
	logic accept;
	logic dw_done;

	opcode_e op_q;
	logic [31:0] addr_q;
	logic [COUNT_W-1:0] words_left;

	host_req_t item;
	logic item_last;
	logic item_pend;
	host_req_t new_req;
	logic new_item;
	logic new_last;

	logic [CW-1:0] credit_cnt;
	logic fire;

	assign accept = rx_valid && rx_ready;
	assign full_dw = {dword_q, rx_data};
	assign dw_done = accept && (byte_cnt == 2'd3);

	// stall intake only when an item is stuck without credit
	assign rx_ready = run && !(item_pend && credit_cnt == '0);

	assign req.valid = item_pend && (credit_cnt != '0);
	assign req.payload = item;
	assign req.last = item_last;
	assign fire = req.valid;

	// act on each completed dword
	always_comb begin
		state_nx = state;
		new_item = 1'b0;
		new_last = 1'b0;
		new_req = '{opcode: OP_PING, addr: 32'h0, data: 32'h0};
		if (dw_done) begin
			case (state)
				S_ID: state_nx = (full_dw[7:0] == HOST_ID_IN) ? S_CMD : S_DISCARD;
				S_CMD: begin
					case (opcode_e'(full_dw[27:24]))
						OP_PING: begin
							new_item = 1'b1;
							new_last = 1'b1;
							state_nx = S_DISCARD;
						end
						OP_WRITE, OP_READ: state_nx = S_ADDR;
						default: state_nx = S_DISCARD;
					endcase
				end
				S_ADDR: begin
					if (op_q == OP_READ) begin
						new_item = 1'b1;
						new_last = 1'b1;
						new_req.opcode = OP_READ;
						new_req.addr = full_dw;
						state_nx = S_DISCARD;
					end else begin
						state_nx = S_DATA;
					end
				end
				S_DATA: begin
					new_item = 1'b1;
					new_last = (words_left == COUNT_W'(1));
					new_req = '{opcode: OP_WRITE, addr: addr_q, data: full_dw};
					if (new_last) begin
						state_nx = S_DISCARD;
					end
				end
				default: state_nx = state;
			endcase
		end
		// frame boundary always resyncs
		if (accept && rx_last) begin
			state_nx = S_ID;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dword_q <= full_dw[23:0];
		end
		if (dw_done && state == S_CMD) begin
			op_q <= opcode_e'(full_dw[27:24]);
			// a write with count 0 still carries one word
			words_left <= (full_dw[23:0] == '0) ? COUNT_W'(1) : full_dw[23:0];
		end
		if (dw_done && state == S_ADDR) begin
			addr_q <= full_dw;
		end
		if (dw_done && state == S_DATA) begin
			words_left <= words_left - COUNT_W'(1);
		end
		if (new_item) begin
			item <= new_req;
			item_last <= new_last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_ID;
			run <= 1'b0;
			byte_cnt <= '0;
			item_pend <= 1'b0;
			credit_cnt <= CW'(DEPTH);
		end else begin
			run <= 1'b1;
			state <= state_nx;
			if (accept) begin
				byte_cnt <= rx_last ? 2'd0 : byte_cnt + 2'd1;
			end
			if (new_item) begin
				item_pend <= 1'b1;
			end else if (fire) begin
				item_pend <= 1'b0;
			end
			if (fire && !req.credit) begin
				credit_cnt <= credit_cnt - CW'(1);
			end else if (!fire && req.credit) begin
				credit_cnt <= credit_cnt + CW'(1);
			end
		end
	end

endmodule

/* hw/credit_fifo.sv */
// relies on the sender's credit counter to never overfill; DEPTH must be 2 or more
module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,
	credit_if.receiver enq,
	output logic out_valid,
	output payload_t out_payload,
	output logic out_last,
	input logic out_ready
);

	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic last_mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;

	assign push = enq.valid;
	assign pop = out_valid && out_ready;

	assign out_valid = (count != '0);
	assign out_payload = mem[rd_ptr];
	// masked so no stale flag leaks out while empty
	assign out_last = out_valid && last_mem[rd_ptr];

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= enq.payload;
			last_mem[wr_ptr] <= enq.last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			enq.credit <= 1'b0;
		end else begin
			// credit goes back the cycle after a pop
			enq.credit <= pop;
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
			end
			if (push && !pop) begin
				count <= count + CW'(1);
			end else if (pop && !push) begin
				count <= count - CW'(1);
			end
		end
	end

endmodule

/* hw/credit_if.sv */
// one payload per valid beat; sender must hold a credit per beat, receiver pulses credit per freed entry
interface credit_if #(
	parameter type payload_t = logic [7:0]
);

	logic valid;
	payload_t payload;
	// final beat of a command or frame
	logic last;
	// one-cycle pulse, one per entry leaving the receiver
	logic credit;

	modport sender (
		output valid,
		output payload,
		output last,
		input credit
	);

	modport receiver (
		input valid,
		input payload,
		input last,
		output credit
	);

endinterface

/* hw/host_pkg.sv */
// shared protocol constants and types; opcode values above 2 are illegal and get discarded
package host_pkg;

	typedef logic [7:0] byte_t;

	// identification bytes, low byte of the first inbound dword / first outbound byte
	localparam byte_t HOST_ID_IN = 8'hCD;
	localparam byte_t HOST_ID_OUT = 8'hDC;

	// status low nibble values that change the response framing
	localparam logic [3:0] STATUS_ERR = 4'hF;
	localparam logic [3:0] STATUS_DATA = 4'hD;

	// count field in command and status dwords
	localparam int COUNT_W = 24;

	typedef enum logic [3:0] {
		OP_PING = 4'd0,
		OP_WRITE = 4'd1,
		OP_READ = 4'd2
	} opcode_e;

	// one bus transaction for the local master
	typedef struct packed {
		opcode_e opcode;
		logic [31:0] addr;
		logic [31:0] data;
	} host_req_t;

endpackage
